//--- Bender.yml
package:
  name: fetch_stage

sources:
  - files:
      - verilog/fetch_pkg.sv
      - verilog/icache_array.sv
      - verilog/line_refill.sv
      - verilog/fetch_unit.sv
      - verilog/fetch_top.sv
  - target: simulation
    files:
      - sim/fetch_mem_model.sv
      - sim/fetch_tb.sv

//--- files.f
verilog/fetch_pkg.sv
verilog/icache_array.sv
verilog/line_refill.sv
verilog/fetch_unit.sv
verilog/fetch_top.sv
sim/fetch_mem_model.sv
sim/fetch_tb.sv

//--- sim/fetch_mem_model.sv
`timescale 1ns/100ps

module fetch_mem_model (
  input  logic             clock,
  input  logic             reset,
  input  fetch_pkg::addr_t araddr,
  input  logic             arvalid,
  output logic             arready,
  input  logic             rready,
  output fetch_pkg::word_t rdata,
  output logic             rvalid,
  output logic             rlast
);

  // Every beat returns its own byte address with this pattern folded in
  localparam fetch_pkg::word_t data_pattern = 32'ha5a5_0000;
  localparam int max_wait = 100;

  integer           seed;
  int               beat;
  int               waited;
  fetch_pkg::addr_t line_addr;

  // Waits 0 to 5 falling edges before the next response step
  task automatic random_delay();
    int cycles;
    cycles = $unsigned($random(seed)) % 6;
    repeat (cycles) @(negedge clock);
  endtask

  // ========================================
  // Burst responder
  // ========================================

  initial begin
    seed = 64097;
    arready = 1'b0;
    rvalid = 1'b0;
    rlast = 1'b0;
    rdata = '0;
    forever begin
      @(negedge clock);
      if (!reset && arvalid) begin
        line_addr = araddr;
        random_delay();
        arready = 1'b1;
        @(negedge clock);
        arready = 1'b0;
        for (beat = 0; beat < 2; beat++) begin
          random_delay();
          rdata = (line_addr + beat * 4) ^ data_pattern;
          rvalid = 1'b1;
          rlast = (beat == 1);
          // The beat moves at the first rising edge that also sees rready
          waited = 0;
          while (!rready && waited < max_wait) begin
            @(negedge clock);
            waited++;
          end
          @(negedge clock);
          rvalid = 1'b0;
          rlast = 1'b0;
        end
      end
    end
  end

endmodule

//--- sim/fetch_tb.sv
`timescale 1ns/100ps

module fetch_tb;

  localparam fetch_pkg::addr_t reset_pc = 32'h3000_0000;
  localparam fetch_pkg::addr_t uncached_base = 32'h0f00_0000;
  localparam fetch_pkg::word_t data_pattern = 32'ha5a5_0000;
  localparam int cycles_per_fetch = 100;

  logic             clock;
  logic             reset;
  logic             inst_valid;
  fetch_pkg::word_t inst;
  fetch_pkg::addr_t old_pc;
  logic             refill_busy;
  logic             idu_ready;
  logic             block;
  logic             clear_pipeline;
  fetch_pkg::addr_t npc;
  logic             clear_cache;
  fetch_pkg::addr_t araddr;
  logic             arvalid;
  logic             arready;
  logic             rready;
  fetch_pkg::word_t rdata;
  logic             rvalid;
  logic             rlast;

  integer seed;
  int     bursts;
  int     errors;
  int     tests;
  int     failed_tests;
  string  test_name;

  fetch_top #(
    .index_bits (4),
    .reset_pc   (reset_pc)
  ) DUT (
    .clock          (clock),
    .reset          (reset),
    .inst_valid     (inst_valid),
    .inst           (inst),
    .old_pc         (old_pc),
    .refill_busy    (refill_busy),
    .idu_ready      (idu_ready),
    .block          (block),
    .clear_pipeline (clear_pipeline),
    .npc            (npc),
    .clear_cache    (clear_cache),
    .araddr         (araddr),
    .arvalid        (arvalid),
    .arready        (arready),
    .rready         (rready),
    .rdata          (rdata),
    .rvalid         (rvalid),
    .rlast          (rlast)
  );

  fetch_mem_model u_mem (
    .clock   (clock),
    .reset   (reset),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rready  (rready),
    .rdata   (rdata),
    .rvalid  (rvalid),
    .rlast   (rlast)
  );

  always #4 clock = ~clock;

  // ========================================
  // Reporting
  // ========================================

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
    errors++;
  endtask

  task automatic report_failure(input string name, input string what);
    $display("[ERROR] %s: %s", name, what);
    errors++;
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests++;
    if (errors == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      failed_tests++;
      $display("test %s: %0d errors", name, errors - errors_before);
    end
  endtask

  // Each address handshake at the top level must be line aligned
  always @(posedge clock) begin
    if (!reset && arvalid && arready) begin
      bursts++;
      if (araddr[2:0] != 3'b000) begin
        report_mismatch(test_name, {araddr[31:3], 3'b000}, araddr);
      end
    end
    // A burst in progress lies between refill_start and refill_done
    if (!reset && (arvalid || rready) && !refill_busy) begin
      report_failure(test_name, "refill_busy was low during a burst");
    end
  end

  // ========================================
  // Stimulus helpers
  // ========================================

  task automatic redirect(input fetch_pkg::addr_t target);
    npc = target;
    clear_pipeline = 1'b1;
    @(negedge clock);
    clear_pipeline = 1'b0;
  endtask

  // Accepts count instructions upward from start_pc and checks each one.
  // With stall set, idu_ready and block follow random spans.
  task automatic fetch_sequence(input string name, input fetch_pkg::addr_t start_pc,
                                input int count, input bit jump, input bit stall);
    fetch_pkg::addr_t expected_pc;
    fetch_pkg::addr_t held_pc;
    fetch_pkg::word_t held_inst;
    logic             held;
    int               got;
    int               waited;
    int               span;
    int               kind;
    test_name = name;
    expected_pc = start_pc;
    held_pc = '0;
    held_inst = '0;
    held = 1'b0;
    got = 0;
    waited = 0;
    span = 0;
    kind = 0;
    if (jump) begin
      redirect(start_pc);
    end
    while (got < count && waited < count * cycles_per_fetch) begin
      if (held) begin
        if (!inst_valid) begin
          report_failure(name, "an instruction vanished before it was accepted");
        end
        if (inst !== held_inst) begin
          report_mismatch(name, held_inst, inst);
        end
        if (old_pc !== held_pc) begin
          report_mismatch(name, held_pc, old_pc);
        end
      end
      if (stall && span == 0) begin
        span = $unsigned($random(seed)) % 4;
        kind = $unsigned($random(seed)) % 3;
      end else if (span > 0) begin
        span--;
      end
      idu_ready = (kind != 1);
      block = (kind == 2);
      if (inst_valid && idu_ready) begin
        if (old_pc !== expected_pc) begin
          report_mismatch(name, expected_pc, old_pc);
        end
        if (inst !== (expected_pc ^ data_pattern)) begin
          report_mismatch(name, expected_pc ^ data_pattern, inst);
        end
        expected_pc = expected_pc + 32'd4;
        got++;
        held = 1'b0;
        // No prefetch behind the last instruction
        if (got == count) begin
          block = 1'b1;
        end
      end else begin
        held = inst_valid;
        held_inst = inst;
        held_pc = old_pc;
      end
      @(negedge clock);
      waited++;
    end
    if (got < count) begin
      report_failure(name, "timed out waiting for an instruction");
    end
    block = 1'b1;
  endtask

  // ========================================
  // Tests
  // ========================================

  task automatic test_cold_fetch();
    int errors_before;
    int bursts_before;
    errors_before = errors;
    bursts_before = bursts;
    if (inst_valid || arvalid || rready || refill_busy) begin
      report_failure("cold_fetch", "outputs were not idle after reset");
    end
    fetch_sequence("cold_fetch", reset_pc, 32, 1'b0, 1'b0);
    if (bursts - bursts_before != 16) begin
      report_mismatch("cold_fetch", 16, bursts - bursts_before);
    end
    finish_test("cold_fetch", errors_before);
  endtask

  task automatic test_hits_conflict();
    int errors_before;
    int bursts_before;
    errors_before = errors;
    bursts_before = bursts;
    fetch_sequence("hits_conflict", reset_pc, 32, 1'b1, 1'b0);
    if (bursts != bursts_before) begin
      report_mismatch("hits_conflict", bursts_before, bursts);
    end
    // The same indices with other tags replace every line
    bursts_before = bursts;
    fetch_sequence("hits_conflict", reset_pc + 32'h80, 32, 1'b1, 1'b0);
    if (bursts - bursts_before != 16) begin
      report_mismatch("hits_conflict", 16, bursts - bursts_before);
    end
    finish_test("hits_conflict", errors_before);
  endtask

  task automatic test_uncached();
    int errors_before;
    int bursts_before;
    int pass;
    errors_before = errors;
    for (pass = 0; pass < 2; pass++) begin
      bursts_before = bursts;
      fetch_sequence("uncached", uncached_base, 8, 1'b1, 1'b0);
      if (bursts - bursts_before != 8) begin
        report_mismatch("uncached", 8, bursts - bursts_before);
      end
    end
    finish_test("uncached", errors_before);
  endtask

  task automatic test_redirect_refill();
    int errors_before;
    int waited;
    errors_before = errors;
    redirect(32'h3000_0200);
    block = 1'b0;
    idu_ready = 1'b1;
    waited = 0;
    while (!refill_busy && waited < cycles_per_fetch) begin
      @(negedge clock);
      waited++;
    end
    if (!refill_busy) begin
      report_failure("redirect_refill", "no refill started for the first address");
    end
    redirect(32'h3000_0100);
    fetch_sequence("redirect_refill", 32'h3000_0100, 4, 1'b0, 1'b0);
    finish_test("redirect_refill", errors_before);
  endtask

  task automatic test_invalidate();
    int errors_before;
    int bursts_before;
    errors_before = errors;
    fetch_sequence("invalidate", 32'h3000_0100, 8, 1'b1, 1'b0);
    bursts_before = bursts;
    fetch_sequence("invalidate", 32'h3000_0100, 8, 1'b1, 1'b0);
    if (bursts != bursts_before) begin
      report_mismatch("invalidate", bursts_before, bursts);
    end
    clear_cache = 1'b1;
    @(negedge clock);
    clear_cache = 1'b0;
    bursts_before = bursts;
    fetch_sequence("invalidate", 32'h3000_0100, 8, 1'b1, 1'b0);
    if (bursts - bursts_before != 4) begin
      report_mismatch("invalidate", 4, bursts - bursts_before);
    end
    finish_test("invalidate", errors_before);
  endtask

  task automatic test_back_pressure();
    int errors_before;
    errors_before = errors;
    fetch_sequence("back_pressure", reset_pc, 24, 1'b1, 1'b1);
    finish_test("back_pressure", errors_before);
  endtask

  initial begin
    seed = 64097;
    bursts = 0;
    errors = 0;
    tests = 0;
    failed_tests = 0;
    test_name = "";
    clock = 1'b0;
    reset = 1'b1;
    idu_ready = 1'b0;
    block = 1'b0;
    clear_pipeline = 1'b0;
    npc = '0;
    clear_cache = 1'b0;
    repeat (16) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    test_cold_fetch();
    test_hits_conflict();
    test_uncached();
    test_redirect_refill();
    test_invalidate();
    test_back_pressure();

    $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- verilog/fetch_pkg.sv
package fetch_pkg;

  // ========================================
  // Widths
  // ========================================

  localparam int addr_bits = 32;
  localparam int word_bits = 32;
  localparam int line_words = 2;
  localparam int line_bits = word_bits * line_words;

  // Byte offset inside one cache line of two words
  localparam int line_offset_bits = 3;

  typedef logic [addr_bits-1:0] addr_t;
  typedef logic [word_bits-1:0] word_t;
  typedef logic [line_bits-1:0] line_t;

  // ========================================
  // Address map
  // ========================================

  // Top address byte of the region that bypasses the cache
  localparam logic [7:0] uncached_prefix = 8'h0f;

  // ========================================
  // State machines
  // ========================================

  typedef enum logic {
    fetch_lookup,
    fetch_refill
  } fetch_state_t;

  typedef enum logic [1:0] {
    refill_idle,
    refill_address,
    refill_data
  } refill_state_t;

endpackage

//--- verilog/fetch_top.sv
`timescale 1ns/100ps

module fetch_top #(
  parameter int               index_bits = 4,
  parameter fetch_pkg::addr_t reset_pc = 32'h3000_0000
) (
  input  logic                clock,
  input  logic                reset,

  // Decode side
  output logic                inst_valid,
  output fetch_pkg::word_t    inst,
  output fetch_pkg::addr_t    old_pc,
  output logic                refill_busy,
  input  logic                idu_ready,
  input  logic                block,

  // Control
  input  logic                clear_pipeline,
  input  fetch_pkg::addr_t    npc,
  input  logic                clear_cache,

  // Memory read channel
  output fetch_pkg::addr_t    araddr,
  output logic                arvalid,
  input  logic                arready,
  output logic                rready,
  input  fetch_pkg::word_t    rdata,
  input  logic                rvalid,
  input  logic                rlast
);

  fetch_pkg::addr_t lookup_addr;
  logic             hit;
  fetch_pkg::line_t hit_line;
  logic             fill_valid;
  fetch_pkg::addr_t fill_addr;
  fetch_pkg::line_t fill_line;
  logic             refill_start;
  fetch_pkg::addr_t refill_addr;
  logic             refill_done;
  fetch_pkg::line_t refill_line;

  fetch_unit #(
    .reset_pc (reset_pc)
  ) u_fetch_unit (
    .clock          (clock),
    .reset          (reset),
    .npc            (npc),
    .clear_pipeline (clear_pipeline),
    .idu_ready      (idu_ready),
    .block          (block),
    .inst_valid     (inst_valid),
    .inst           (inst),
    .old_pc         (old_pc),
    .lookup_addr    (lookup_addr),
    .hit            (hit),
    .hit_line       (hit_line),
    .fill_valid     (fill_valid),
    .fill_addr      (fill_addr),
    .fill_line      (fill_line),
    .refill_start   (refill_start),
    .refill_addr    (refill_addr),
    .refill_done    (refill_done),
    .refill_line    (refill_line)
  );

  icache_array #(
    .index_bits (index_bits)
  ) u_icache_array (
    .clock       (clock),
    .reset       (reset),
    .clear_cache (clear_cache),
    .lookup_addr (lookup_addr),
    .hit         (hit),
    .hit_line    (hit_line),
    .fill_valid  (fill_valid),
    .fill_addr   (fill_addr),
    .fill_line   (fill_line)
  );

  line_refill u_line_refill (
    .clock        (clock),
    .reset        (reset),
    .refill_start (refill_start),
    .refill_addr  (refill_addr),
    .refill_done  (refill_done),
    .refill_line  (refill_line),
    .refill_busy  (refill_busy),
    .araddr       (araddr),
    .arvalid      (arvalid),
    .arready      (arready),
    .rready       (rready),
    .rdata        (rdata),
    .rvalid       (rvalid),
    .rlast        (rlast)
  );

endmodule

//--- verilog/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit #(
  parameter fetch_pkg::addr_t reset_pc = 32'h3000_0000
) (
  input  logic                clock,
  input  logic                reset,
  input  fetch_pkg::addr_t    npc,
  input  logic                clear_pipeline,
  input  logic                idu_ready,
  input  logic                block,
  output logic                inst_valid,
  output fetch_pkg::word_t    inst,
  output fetch_pkg::addr_t    old_pc,
  output fetch_pkg::addr_t    lookup_addr,
  input  logic                hit,
  input  fetch_pkg::line_t    hit_line,
  output logic                fill_valid,
  output fetch_pkg::addr_t    fill_addr,
  output fetch_pkg::line_t    fill_line,
  output logic                refill_start,
  output fetch_pkg::addr_t    refill_addr,
  input  logic                refill_done,
  input  fetch_pkg::line_t    refill_line
);

  // Address bit that picks the high word of a line
  localparam int word_sel = fetch_pkg::line_offset_bits - 1;
  localparam int top = fetch_pkg::addr_bits - 1;

  fetch_pkg::fetch_state_t state;
  fetch_pkg::addr_t        pc;
  fetch_pkg::addr_t        miss_pc;
  logic                    discard;

  logic             accepted;
  logic             advance;
  logic             pc_uncached;
  logic             miss_uncached;
  logic             take_hit;
  fetch_pkg::word_t hit_word;
  fetch_pkg::word_t refill_word;

  // ========================================
  // Lookup and word select
  // ========================================

  assign lookup_addr = pc;

  assign accepted = inst_valid && idu_ready;
  assign advance = !block && (!inst_valid || idu_ready);

  assign pc_uncached = (pc[top -: 8] == fetch_pkg::uncached_prefix);
  assign miss_uncached = (miss_pc[top -: 8] == fetch_pkg::uncached_prefix);

  // Uncached addresses always go to memory even if a stale entry matches
  assign take_hit = hit && !pc_uncached;

  assign hit_word = pc[word_sel] ? hit_line[63:32] : hit_line[31:0];
  assign refill_word = miss_pc[word_sel] ? refill_line[63:32] : refill_line[31:0];

  assign refill_addr = miss_pc;

  // The returned line goes into the cache in the same cycle as refill_done
  assign fill_valid = refill_done && !miss_uncached;
  assign fill_addr = miss_pc;
  assign fill_line = refill_line;

  // ========================================
  // Control state
  // ========================================

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= fetch_pkg::fetch_lookup;
      pc <= reset_pc;
      inst_valid <= 1'b0;
      refill_start <= 1'b0;
      discard <= 1'b0;
    end else begin
      refill_start <= 1'b0;

      if (accepted) begin
        inst_valid <= 1'b0;
      end

      // A redirect beats any advance in the same cycle
      if (clear_pipeline) begin
        pc <= npc;
        inst_valid <= 1'b0;
      end

      case (state)
        fetch_pkg::fetch_lookup: begin
          if (advance && !clear_pipeline) begin
            if (take_hit) begin
              pc <= pc + 32'd4;
              inst_valid <= 1'b1;
            end else begin
              state <= fetch_pkg::fetch_refill;
              refill_start <= 1'b1;
              inst_valid <= 1'b0;
            end
          end
        end
        fetch_pkg::fetch_refill: begin
          if (refill_done) begin
            state <= fetch_pkg::fetch_lookup;
            discard <= 1'b0;
            if (!discard && !clear_pipeline) begin
              pc <= miss_pc + 32'd4;
              inst_valid <= 1'b1;
            end
          end else if (clear_pipeline) begin
            // The burst runs to the end, only its instruction is dropped
            discard <= 1'b1;
          end
        end
        default: begin
          state <= fetch_pkg::fetch_lookup;
        end
      endcase
    end
  end

  // ========================================
  // Instruction output and miss address
  // ========================================

  always_ff @(posedge clock) begin
    if (!reset && !clear_pipeline) begin
      if (state == fetch_pkg::fetch_lookup && advance) begin
        if (take_hit) begin
          inst <= hit_word;
          old_pc <= pc;
        end else begin
          miss_pc <= pc;
        end
      end
      if (state == fetch_pkg::fetch_refill && refill_done && !discard) begin
        inst <= refill_word;
        old_pc <= miss_pc;
      end
    end
  end

  // ========================================
  // Checks
  // ========================================

  // Only one refill is outstanding, and only while this unit waits for it
  done_only_while_waiting: assert property (
    @(posedge clock) disable iff (reset)
    refill_done |-> (state == fetch_pkg::fetch_refill)
  );

endmodule

//--- verilog/icache_array.sv
`timescale 1ns/100ps

module icache_array #(
  parameter int index_bits = 4
) (
  input  logic                clock,
  input  logic                reset,
  input  logic                clear_cache,
  input  fetch_pkg::addr_t    lookup_addr,
  output logic                hit,
  output fetch_pkg::line_t    hit_line,
  input  logic                fill_valid,
  input  fetch_pkg::addr_t    fill_addr,
  input  fetch_pkg::line_t    fill_line
);

  localparam int entries = 2 ** index_bits;
  localparam int tag_bits = fetch_pkg::addr_bits - index_bits - fetch_pkg::line_offset_bits;

  typedef logic [tag_bits-1:0] tag_t;
  typedef logic [index_bits-1:0] index_t;

  // ========================================
  // Storage
  // ========================================

  logic [entries-1:0] valid;
  tag_t               tag_mem [entries];
  fetch_pkg::line_t   data_mem [entries];

  index_t lookup_index;
  tag_t   lookup_tag;
  index_t fill_index;
  tag_t   fill_tag;

  assign lookup_index = lookup_addr[fetch_pkg::line_offset_bits +: index_bits];
  assign lookup_tag = lookup_addr[fetch_pkg::addr_bits-1 -: tag_bits];
  assign fill_index = fill_addr[fetch_pkg::line_offset_bits +: index_bits];
  assign fill_tag = fill_addr[fetch_pkg::addr_bits-1 -: tag_bits];

  // Lookup is purely combinational so the fetch unit can decide in the same cycle
  assign hit = valid[lookup_index] && (tag_mem[lookup_index] == lookup_tag);
  assign hit_line = data_mem[lookup_index];

  always_ff @(posedge clock) begin
    if (reset || clear_cache) begin
      valid <= '0;
    end else if (fill_valid) begin
      valid[fill_index] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (fill_valid) begin
      tag_mem[fill_index] <= fill_tag;
      data_mem[fill_index] <= fill_line;
    end
  end

  // ========================================
  // Checks
  // ========================================

  // A flush racing a fill would leave the line state ambiguous
  fill_not_during_clear: assert property (
    @(posedge clock) disable iff (reset)
    !(fill_valid && clear_cache)
  );

endmodule

//--- verilog/line_refill.sv
`timescale 1ns/100ps

module line_refill (
  input  logic                clock,
  input  logic                reset,
  input  logic                refill_start,
  input  fetch_pkg::addr_t    refill_addr,
  output logic                refill_done,
  output fetch_pkg::line_t    refill_line,
  output logic                refill_busy,
  output fetch_pkg::addr_t    araddr,
  output logic                arvalid,
  input  logic                arready,
  output logic                rready,
  input  fetch_pkg::word_t    rdata,
  input  logic                rvalid,
  input  logic                rlast
);

  fetch_pkg::refill_state_t state;
  fetch_pkg::word_t         low_word;
  logic                     high_beat;
  logic                     beat;

  assign beat = rvalid && rready;

  // Busy covers the start pulse, the whole burst and the done pulse
  assign refill_busy = refill_start || refill_done || (state != fetch_pkg::refill_idle);

  // ========================================
  // Burst control
  // ========================================

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= fetch_pkg::refill_idle;
      arvalid <= 1'b0;
      rready <= 1'b0;
      refill_done <= 1'b0;
      high_beat <= 1'b0;
    end else begin
      refill_done <= 1'b0;
      case (state)
        fetch_pkg::refill_idle: begin
          if (refill_start) begin
            state <= fetch_pkg::refill_address;
            arvalid <= 1'b1;
          end
        end
        fetch_pkg::refill_address: begin
          if (arready) begin
            state <= fetch_pkg::refill_data;
            arvalid <= 1'b0;
            rready <= 1'b1;
            high_beat <= 1'b0;
          end
        end
        fetch_pkg::refill_data: begin
          if (beat) begin
            if (rlast) begin
              state <= fetch_pkg::refill_idle;
              rready <= 1'b0;
              refill_done <= 1'b1;
            end else begin
              high_beat <= 1'b1;
            end
          end
        end
        default: begin
          state <= fetch_pkg::refill_idle;
        end
      endcase
    end
  end

  // ========================================
  // Address and line assembly
  // ========================================

  always_ff @(posedge clock) begin
    if (state == fetch_pkg::refill_idle && refill_start) begin
      araddr <= {refill_addr[fetch_pkg::addr_bits-1:fetch_pkg::line_offset_bits],
                 {fetch_pkg::line_offset_bits{1'b0}}};
    end
    if (state == fetch_pkg::refill_data && beat) begin
      if (rlast) begin
        refill_line <= {rdata, low_word};
      end else begin
        low_word <= rdata;
      end
    end
  end

  // ========================================
  // Checks
  // ========================================

  ar_stable_while_waiting: assert property (
    @(posedge clock) disable iff (reset)
    arvalid && !arready |=> arvalid && $stable(araddr)
  );

  // The line is exactly two beats, so rlast marks the second one
  rlast_on_second_beat: assert property (
    @(posedge clock) disable iff (reset)
    beat |-> (rlast == high_beat)
  );

endmodule
